// ==== verification/gpu_node_testdata.txt ====
# op id addr data strb resp expected back-pressure (hex, last column decimal)
# W write, L write with len 1, R read, S stall (addr 1 holds net_ready_in), I inject (expected = net_ready_out)
W 1 00000040 1122334455667788 ff 0 0 0
R 2 00000040 0 0 0 1122334455667788 0
W 3 00000040 aabbccddeeff0011 5a 0 0 2
R 4 00000040 0 0 0 11bb33ddee660088 3
L 5 00000040 ffffffffffffffff ff 2 0 0
R 6 00000040 0 0 0 11bb33ddee660088 0
R 7 00002040 0 0 3 0 0
W 8 00002010 1 ff 2 0 4
R 9 00002000 0 0 2 0 0
W a 00002000 1555 ff 0 0 0
S 0 0 0 0 0 0 30
S 0 1 0 0 0 0 1
W b 00002000 0c21 ff 0 0 0
W c 00002000 0fff ff 2 0 0
R d 00002010 0 0 0 100 0
S 0 0 0 0 0 0 30
R e 00002010 0 0 0 0 0
I 0 5c01 0 0 0 1 0
I 0 0401 0 0 0 1 0
I 0 5c02 0 0 0 1 0
R 1 00002008 0 0 0 15c01 0
R 2 00002008 0 0 0 15c02 0
R 3 00002008 0 0 0 0 0
R 4 00002010 0 0 0 10000 0
I 0 5c11 0 0 0 1 0
I 0 5c12 0 0 0 1 0
I 0 5c13 0 0 0 1 0
I 0 5c14 0 0 0 1 0
I 0 5c15 0 0 0 0 0
R 5 00002010 0 0 0 10004 0
R 6 00002008 0 0 0 15c11 0
R 7 00002010 0 0 0 10004 0
R 8 00002008 0 0 0 15c12 0
R 9 00002008 0 0 0 15c13 0
R a 00002008 0 0 0 15c14 0
R b 00002008 0 0 0 15c15 0

// ==== all.f ====
source/gpu_pkg.sv
source/node_axi_slave.sv
source/local_memory.sv
source/net_interface.sv
source/gpu_node.sv
verification/gpu_node_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f all.f --top-module gpu_node_tb -o gpu_node_sim \
    > build.log 2>&1 &&
./obj_dir/gpu_node_sim > sim.log 2>&1 ||
{ echo "Build or simulation did not run, see build.log and sim.log"; exit 1; }
grep -q "ERRORS FOUND" sim.log && { echo "Simulation reported errors"; exit 1; } ||
echo "Simulation passed"

// ==== verification/gpu_node_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module gpu_node_tb;

    localparam int CLK_HALF     = 20;
    localparam int HS_LIMIT     = 64;
    localparam int RD_LAT_EDGES = 3;
    localparam int MAX_OPS      = 64;

    logic                   ACLK = 1'b0;
    logic                   ARESETn;
    gpu_pkg::axi_aw_t       aw;
    logic                   aw_valid;
    logic                   aw_ready;
    gpu_pkg::axi_w_t        w;
    logic                   w_valid;
    logic                   w_ready;
    gpu_pkg::axi_b_t        b;
    logic                   b_valid;
    logic                   bready;
    gpu_pkg::axi_ar_t       ar;
    logic                   ar_valid;
    logic                   ar_ready;
    gpu_pkg::axi_r_t        r;
    logic                   r_valid;
    logic                   rready;
    gpu_pkg::flit_t         net_tx;
    logic                   net_valid_out;
    logic                   net_ready_in = 1'b0;
    gpu_pkg::flit_t         net_rx = '0;
    logic                   net_valid_in = 1'b0;
    logic                   net_ready_out;

    int                     errors = 0;
    int                     tx_errors = 0;
    int                     cycles = 0;
    int                     cycle_limit = 1000;
    int                     seed = 32'h5a46_f90b;
    logic [31:0]            rnd_word;
    logic                   tx_hold = 1'b0;
    int                     inject_seq = 0;
    int                     inject_done = 0;
    gpu_pkg::flit_t         inject_flit = '0;
    gpu_pkg::flit_t         tx_exp_mem [MAX_OPS];
    int                     tx_exp_wr = 0;
    int                     tx_exp_rd = 0;

    // Testdata columns
    byte                    op_code [MAX_OPS];
    logic [63:0]            f_id [MAX_OPS];
    logic [63:0]            f_addr [MAX_OPS];
    logic [63:0]            f_data [MAX_OPS];
    logic [63:0]            f_strb [MAX_OPS];
    logic [63:0]            f_resp [MAX_OPS];
    logic [63:0]            f_exp [MAX_OPS];
    int                     f_bp [MAX_OPS];
    int                     n_ops = 0;

    gpu_node #(
        .node_id (6'd23)
    ) UUT (.*);

    initial begin
        forever #(CLK_HALF) ACLK = ~ACLK;
    end

    always @(posedge ACLK) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Run aborted, no progress after %0d cycles", cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // Network side drives a random ready and one injected flit at a time
    always @(posedge ACLK) begin
        rnd_word = $random(seed);
        net_ready_in <= tx_hold ? 1'b0 : rnd_word[0];
        if (net_valid_in && net_ready_out) begin
            net_valid_in <= 1'b0;
            inject_done  <= inject_done + 1;
        end else if (!net_valid_in && inject_seq != inject_done) begin
            net_rx       <= inject_flit;
            net_valid_in <= 1'b1;
        end
    end

    // Transmitted flits must match the REG_TX writes in order
    always @(posedge ACLK) begin
        if (net_valid_out && net_ready_in) begin
            if (tx_exp_rd == tx_exp_wr) begin
                $display("Flit %h left on net_tx without a matching TX write", net_tx);
                tx_errors++;
            end else begin
                if (net_tx !== tx_exp_mem[tx_exp_rd]) begin
                    $display("[FAIL] net_tx expected %h got %h", tx_exp_mem[tx_exp_rd], net_tx);
                    tx_errors++;
                end
                tx_exp_rd <= tx_exp_rd + 1;
            end
        end
    end

    task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %h got %h", name, exp, act);
            errors++;
        end
    endtask

    // A stray ar during back-pressure must not be taken
    task automatic hold_response(input int bp);
        ar <= '{id: 4'hf, addr: 32'h0, len: 8'd0, size: 3'd3, burst: 2'b01};
        ar_valid <= (bp != 0);
        repeat (bp) begin
            @(posedge ACLK);
            check_val("ar_ready", 64'd0, ar_ready);
        end
        ar_valid <= 1'b0;
    endtask

    task automatic do_write(input logic [63:0] id, input logic [63:0] addr,
                            input logic [63:0] data, input logic [63:0] strb,
                            input logic [7:0] len, input logic [63:0] resp, input int bp);
        int              n;
        bit              aw_done;
        bit              w_done;
        gpu_pkg::axi_b_t held;
        if (addr == gpu_pkg::REG_TX && resp == gpu_pkg::RESP_OKAY && len == 0) begin
            tx_exp_mem[tx_exp_wr] = data[15:0];
            tx_exp_wr++;
        end
        @(posedge ACLK);
        aw <= '{id: id[3:0], addr: addr[31:0], len: len, size: 3'd3, burst: 2'b01};
        w <= '{data: data, strb: strb[7:0], last: 1'b1};
        aw_valid <= 1'b1;
        w_valid <= 1'b1;
        aw_done = 0;
        w_done = 0;
        n = 0;
        while (!(aw_done && w_done) && n < HS_LIMIT) begin
            @(posedge ACLK);
            n++;
            if (aw_valid && aw_ready) begin
                aw_valid <= 1'b0;
                aw_done = 1;
            end
            if (w_valid && w_ready) begin
                w_valid <= 1'b0;
                w_done = 1;
            end
        end
        if (!(aw_done && w_done)) begin
            $display("Write to %h never completed its address or data handshake", addr);
            errors++;
            return;
        end
        n = 0;
        while (!b_valid && n < HS_LIMIT) begin
            @(posedge ACLK);
            n++;
        end
        if (!b_valid) begin
            $display("Write to %h never produced a write response", addr);
            errors++;
            return;
        end
        held = b;
        hold_response(bp);
        check_val("b_valid", 64'd1, b_valid);
        check_val("b", held, b);
        bready <= 1'b1;
        @(posedge ACLK);
        check_val("b.id", id, b.id);
        check_val("b.resp", resp, b.resp);
        bready <= 1'b0;
    endtask

    task automatic do_read(input logic [63:0] id, input logic [63:0] addr,
                           input logic [63:0] resp, input logic [63:0] exp, input int bp);
        int              n;
        bit              ar_done;
        gpu_pkg::axi_r_t held;
        @(posedge ACLK);
        ar <= '{id: id[3:0], addr: addr[31:0], len: 8'd0, size: 3'd3, burst: 2'b01};
        ar_valid <= 1'b1;
        ar_done = 0;
        n = 0;
        while (!ar_done && n < HS_LIMIT) begin
            @(posedge ACLK);
            n++;
            ar_done = ar_valid && ar_ready;
        end
        ar_valid <= 1'b0;
        if (!ar_done) begin
            $display("Read of %h never completed its address handshake", addr);
            errors++;
            return;
        end
        n = 0;
        do begin
            @(posedge ACLK);
            n++;
        end while (!r_valid && n < HS_LIMIT);
        check_val("r_valid latency", RD_LAT_EDGES, n);
        if (!r_valid) begin
            $display("Read of %h never returned data", addr);
            errors++;
            return;
        end
        held = r;
        hold_response(bp);
        check_val("r_valid", 64'd1, r_valid);
        if (r !== held) begin
            $display("[FAIL] r expected %h got %h", held, r);
            errors++;
        end
        rready <= 1'b1;
        @(posedge ACLK);
        check_val("r.id", id, r.id);
        check_val("r.resp", resp, r.resp);
        check_val("r.data", exp, r.data);
        check_val("r.last", 64'd1, r.last);
        rready <= 1'b0;
    endtask

    task automatic wait_inject_idle();
        int n;
        n = 0;
        while (inject_seq != inject_done && n < 4 * HS_LIMIT) begin
            @(posedge ACLK);
            n++;
        end
        if (inject_seq != inject_done) begin
            $display("Injected flit was never accepted by the node");
            errors++;
        end
    endtask

    task automatic inject(input logic [63:0] flit, input logic [63:0] exp_ready);
        wait_inject_idle();
        @(posedge ACLK);
        check_val("net_ready_out", exp_ready, net_ready_out);
        inject_flit <= flit[15:0];
        inject_seq <= inject_seq + 1;
    endtask

    initial begin
        int    fd;
        int    code;
        int    n;
        int    total;
        string tok;
        string line;
        aw = '0;
        w = '0;
        ar = '0;
        aw_valid = 1'b0;
        w_valid = 1'b0;
        ar_valid = 1'b0;
        bready = 1'b0;
        rready = 1'b0;
        ARESETn = 1'b0;
        fd = $fopen("verification/gpu_node_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the testdata file");
            errors++;
        end else begin
            while (!$feof(fd) && n_ops < MAX_OPS) begin
                code = $fscanf(fd, "%s", tok);
                if (code != 1) break;
                if (tok[0] == "#") begin
                    code = $fgets(line, fd);
                end else begin
                    op_code[n_ops] = tok[0];
                    code = $fscanf(fd, " %h %h %h %h %h %h %d", f_id[n_ops], f_addr[n_ops],
                                   f_data[n_ops], f_strb[n_ops], f_resp[n_ops],
                                   f_exp[n_ops], f_bp[n_ops]);
                    n_ops++;
                end
            end
            $fclose(fd);
        end
        cycle_limit = 200 * n_ops + 1000;

        repeat (16) @(posedge ACLK);
        ARESETn <= 1'b1;
        repeat (2) @(posedge ACLK);

        for (int i = 0; i < n_ops; i++) begin
            case (op_code[i])
                "W": do_write(f_id[i], f_addr[i], f_data[i], f_strb[i], 8'd0, f_resp[i], f_bp[i]);
                "L": do_write(f_id[i], f_addr[i], f_data[i], f_strb[i], 8'd1, f_resp[i], f_bp[i]);
                "R": do_read(f_id[i], f_addr[i], f_resp[i], f_exp[i], f_bp[i]);
                "I": inject(f_addr[i], f_exp[i]);
                "S": begin
                    @(posedge ACLK);
                    tx_hold <= f_addr[i][0];
                    repeat (f_bp[i]) @(posedge ACLK);
                end
                default: begin
                    $display("Unknown opcode on testdata entry %0d", i);
                    errors++;
                end
            endcase
        end

        wait_inject_idle();
        n = 0;
        while (tx_exp_rd != tx_exp_wr && n < 4 * HS_LIMIT) begin
            @(posedge ACLK);
            n++;
        end
        if (tx_exp_rd != tx_exp_wr) begin
            $display("Some written TX flits never appeared on net_tx");
            errors++;
        end
        total = errors + tx_errors;
        $display("Run finished after %0d operations with %0d bus and %0d flit errors",
                 n_ops, errors, tx_errors);
        if (total == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/gpu_node.sv ====
`timescale 1ns/1ps
`default_nettype none

module gpu_node #(
    parameter gpu_pkg::node_id_t node_id = 6'd23
) (
    input  logic              ACLK,
    input  logic              ARESETn,
    input  gpu_pkg::axi_aw_t  aw,
    input  logic              aw_valid,
    output logic              aw_ready,
    input  gpu_pkg::axi_w_t   w,
    input  logic              w_valid,
    output logic              w_ready,
    output gpu_pkg::axi_b_t   b,
    output logic              b_valid,
    input  logic              bready,
    input  gpu_pkg::axi_ar_t  ar,
    input  logic              ar_valid,
    output logic              ar_ready,
    output gpu_pkg::axi_r_t   r,
    output logic              r_valid,
    input  logic              rready,
    output gpu_pkg::flit_t    net_tx,
    output logic              net_valid_out,
    input  logic              net_ready_in,
    input  gpu_pkg::flit_t    net_rx,
    input  logic              net_valid_in,
    output logic              net_ready_out
);

    gpu_pkg::mem_req_t    mem_req;
    logic                 mem_access;
    gpu_pkg::data_t       mem_rdata;
    gpu_pkg::reg_req_t    reg_req;
    gpu_pkg::reg_status_t reg_status;

    node_axi_slave u_slave (
        .ACLK       (ACLK),
        .ARESETn    (ARESETn),
        .aw         (aw),
        .aw_valid   (aw_valid),
        .aw_ready   (aw_ready),
        .w          (w),
        .w_valid    (w_valid),
        .w_ready    (w_ready),
        .b          (b),
        .b_valid    (b_valid),
        .bready     (bready),
        .ar         (ar),
        .ar_valid   (ar_valid),
        .ar_ready   (ar_ready),
        .r          (r),
        .r_valid    (r_valid),
        .rready     (rready),
        .mem_req    (mem_req),
        .mem_access (mem_access),
        .mem_rdata  (mem_rdata),
        .reg_req    (reg_req),
        .reg_status (reg_status)
    );

    local_memory u_mem (
        .ACLK       (ACLK),
        .mem_access (mem_access),
        .mem_req    (mem_req),
        .rdata      (mem_rdata)
    );

    net_interface #(
        .node_id (node_id)
    ) u_ni (
        .ACLK          (ACLK),
        .ARESETn       (ARESETn),
        .reg_req       (reg_req),
        .reg_status    (reg_status),
        .net_tx        (net_tx),
        .net_valid_out (net_valid_out),
        .net_ready_in  (net_ready_in),
        .net_rx        (net_rx),
        .net_valid_in  (net_valid_in),
        .net_ready_out (net_ready_out)
    );

endmodule

`default_nettype wire

// ==== source/net_interface.sv ====
`timescale 1ns/1ps
`default_nettype none

module net_interface #(
    parameter gpu_pkg::node_id_t node_id = 6'd23
) (
    input  logic                 ACLK,
    input  logic                 ARESETn,
    input  gpu_pkg::reg_req_t    reg_req,
    output gpu_pkg::reg_status_t reg_status,
    output gpu_pkg::flit_t       net_tx,
    output logic                 net_valid_out,
    input  logic                 net_ready_in,
    input  gpu_pkg::flit_t       net_rx,
    input  logic                 net_valid_in,
    output logic                 net_ready_out
);

    gpu_pkg::flit_t                 tx_flit_q;
    logic                           tx_busy;
    gpu_pkg::flit_t                 rxq [gpu_pkg::RXQ_DEPTH];
    logic [gpu_pkg::RXQ_PTR_W-1:0]  wr_ptr;
    logic [gpu_pkg::RXQ_PTR_W-1:0]  rd_ptr;
    logic [gpu_pkg::RXQ_PTR_W:0]    rx_count;
    logic [7:0]                     drop_count;
    logic                           rx_accept;
    logic                           rx_push;
    logic                           rx_pop;

    // Transmit holding register
    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            tx_busy <= 1'b0;
        end else if (reg_req.tx_write) begin
            tx_busy <= 1'b1;
        end else if (tx_busy && net_ready_in) begin
            tx_busy <= 1'b0;
        end
    end

    always_ff @(posedge ACLK) begin
        if (reg_req.tx_write) begin
            tx_flit_q <= reg_req.tx_flit;
        end
    end

    assign net_tx        = tx_flit_q;
    assign net_valid_out = tx_busy;

    // Receive side accepts everything while there is room
    assign net_ready_out = rx_count != gpu_pkg::RXQ_DEPTH;
    assign rx_accept     = net_valid_in && net_ready_out;
    assign rx_push       = rx_accept && (net_rx.dest == node_id);
    assign rx_pop        = reg_req.rx_pop && (rx_count != '0);

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            rx_count   <= '0;
            drop_count <= '0;
        end else begin
            if (rx_push) wr_ptr <= wr_ptr + 1'b1;
            if (rx_pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({rx_push, rx_pop})
                2'b10:   rx_count <= rx_count + 1'b1;
                2'b01:   rx_count <= rx_count - 1'b1;
                default: rx_count <= rx_count;
            endcase
            // Foreign flits are consumed and counted with a wrap at 255
            if (rx_accept && !rx_push) begin
                drop_count <= drop_count + 1'b1;
            end
        end
    end

    always_ff @(posedge ACLK) begin
        if (rx_push) begin
            rxq[wr_ptr] <= net_rx;
        end
    end

    assign reg_status.rx_head    = rxq[rd_ptr];
    assign reg_status.rx_valid   = rx_count != '0;
    assign reg_status.rx_count   = rx_count;
    assign reg_status.tx_busy    = tx_busy;
    assign reg_status.drop_count = drop_count;

endmodule

`default_nettype wire

// ==== source/local_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module local_memory (
    input  logic              ACLK,
    input  logic              mem_access,
    input  gpu_pkg::mem_req_t mem_req,
    output gpu_pkg::data_t    rdata
);

    gpu_pkg::data_t mem [gpu_pkg::MEM_WORDS];

    // Byte-lane writes and a read that lands one cycle after the access
    always_ff @(posedge ACLK) begin
        if (mem_access) begin
            if (mem_req.we) begin
                for (int lane = 0; lane < $bits(gpu_pkg::strb_t); lane++) begin
                    if (mem_req.strb[lane]) begin
                        mem[mem_req.index][lane*8 +: 8] <= mem_req.wdata[lane*8 +: 8];
                    end
                end
            end else begin
                rdata <= mem[mem_req.index];
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/node_axi_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

module node_axi_slave (
    input  logic                 ACLK,
    input  logic                 ARESETn,
    input  gpu_pkg::axi_aw_t     aw,
    input  logic                 aw_valid,
    output logic                 aw_ready,
    input  gpu_pkg::axi_w_t      w,
    input  logic                 w_valid,
    output logic                 w_ready,
    output gpu_pkg::axi_b_t      b,
    output logic                 b_valid,
    input  logic                 bready,
    input  gpu_pkg::axi_ar_t     ar,
    input  logic                 ar_valid,
    output logic                 ar_ready,
    output gpu_pkg::axi_r_t      r,
    output logic                 r_valid,
    input  logic                 rready,
    output gpu_pkg::mem_req_t    mem_req,
    output logic                 mem_access,
    input  gpu_pkg::data_t       mem_rdata,
    output gpu_pkg::reg_req_t    reg_req,
    input  gpu_pkg::reg_status_t reg_status
);

    gpu_pkg::slave_state_t state;
    gpu_pkg::axi_id_t      id_q;
    gpu_pkg::addr_t        addr_q;
    logic                  len_ok_q;
    gpu_pkg::data_t        reg_rdata_q;
    gpu_pkg::resp_t        wr_resp;
    gpu_pkg::resp_t        rd_resp;
    logic                  hit_mem;
    logic                  hit_tx;
    logic                  hit_rx;
    logic                  hit_status;
    logic                  w_fire;

    // RX word carries the valid flag in bit 16
    // Status word packs count, busy and drops
    function automatic gpu_pkg::data_t format_reg(input gpu_pkg::addr_t addr,
                                                  input gpu_pkg::reg_status_t st);
        gpu_pkg::data_t word;
        word = '0;
        if (addr == gpu_pkg::REG_RX) begin
            if (st.rx_valid) begin
                word[15:0] = st.rx_head;
                word[16]   = 1'b1;
            end
        end else begin
            word[2:0]   = st.rx_count;
            word[8]     = st.tx_busy;
            word[23:16] = st.drop_count;
        end
        return word;
    endfunction

    assign hit_mem    = addr_q < gpu_pkg::MEM_LIMIT;
    assign hit_tx     = addr_q == gpu_pkg::REG_TX;
    assign hit_rx     = addr_q == gpu_pkg::REG_RX;
    assign hit_status = addr_q == gpu_pkg::REG_STATUS;

    always_comb begin
        if (!len_ok_q)                wr_resp = gpu_pkg::RESP_SLVERR;
        else if (hit_mem)             wr_resp = gpu_pkg::RESP_OKAY;
        else if (hit_tx)              wr_resp = reg_status.tx_busy ? gpu_pkg::RESP_SLVERR
                                                                   : gpu_pkg::RESP_OKAY;
        else if (hit_rx || hit_status) wr_resp = gpu_pkg::RESP_SLVERR;
        else                          wr_resp = gpu_pkg::RESP_DECERR;
    end

    always_comb begin
        if (!len_ok_q)                 rd_resp = gpu_pkg::RESP_SLVERR;
        else if (hit_mem)              rd_resp = gpu_pkg::RESP_OKAY;
        else if (hit_rx || hit_status) rd_resp = gpu_pkg::RESP_OKAY;
        else if (hit_tx)               rd_resp = gpu_pkg::RESP_SLVERR;
        else                           rd_resp = gpu_pkg::RESP_DECERR;
    end

    // Write wins when both address channels are valid in idle
    assign aw_ready = state == gpu_pkg::S_IDLE;
    assign ar_ready = (state == gpu_pkg::S_IDLE) && !aw_valid;
    assign w_ready  = state == gpu_pkg::S_WDATA;
    assign b_valid  = state == gpu_pkg::S_WRESP;
    assign r_valid  = state == gpu_pkg::S_RRESP;
    assign w_fire   = w_valid && w_ready;

    assign mem_access    = len_ok_q && hit_mem && (w_fire || state == gpu_pkg::S_RACCESS);
    assign mem_req.we    = state == gpu_pkg::S_WDATA;
    assign mem_req.index = addr_q[12:3];
    assign mem_req.wdata = w.data;
    assign mem_req.strb  = w.strb;

    // Busy transmitter already turned into SLVERR, so no strobe then
    assign reg_req.tx_write = w_fire && hit_tx && (wr_resp == gpu_pkg::RESP_OKAY);
    assign reg_req.rx_pop   = (state == gpu_pkg::S_RACCESS) && hit_rx && len_ok_q;
    assign reg_req.tx_flit  = w.data[15:0];

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            state <= gpu_pkg::S_INIT;
        end else begin
            case (state)
                gpu_pkg::S_INIT:    state <= gpu_pkg::S_IDLE;
                gpu_pkg::S_IDLE: begin
                    if (aw_valid)      state <= gpu_pkg::S_WDATA;
                    else if (ar_valid) state <= gpu_pkg::S_RACCESS;
                end
                gpu_pkg::S_WDATA:   if (w_valid) state <= gpu_pkg::S_WRESP;
                gpu_pkg::S_WRESP:   if (bready) state <= gpu_pkg::S_IDLE;
                gpu_pkg::S_RACCESS: state <= gpu_pkg::S_RWAIT;
                gpu_pkg::S_RWAIT:   state <= gpu_pkg::S_RRESP;
                gpu_pkg::S_RRESP:   if (rready) state <= gpu_pkg::S_IDLE;
                default:            state <= gpu_pkg::S_IDLE;
            endcase
        end
    end

    // Request capture and response payload
    always_ff @(posedge ACLK) begin
        if (state == gpu_pkg::S_IDLE) begin
            if (aw_valid) begin
                id_q     <= aw.id;
                addr_q   <= aw.addr;
                len_ok_q <= aw.len == 8'd0;
            end else if (ar_valid) begin
                id_q     <= ar.id;
                addr_q   <= ar.addr;
                len_ok_q <= ar.len == 8'd0;
            end
        end
        if (w_fire) begin
            b.id   <= id_q;
            b.resp <= wr_resp;
        end
        // Sampled before the pop takes effect
        if (state == gpu_pkg::S_RACCESS) begin
            reg_rdata_q <= format_reg(addr_q, reg_status);
        end
        if (state == gpu_pkg::S_RWAIT) begin
            r.id   <= id_q;
            r.resp <= rd_resp;
            r.last <= 1'b1;
            if (rd_resp != gpu_pkg::RESP_OKAY) r.data <= '0;
            else if (hit_mem)                  r.data <= mem_rdata;
            else                               r.data <= reg_rdata_q;
        end
    end

endmodule

`default_nettype wire

// ==== source/gpu_pkg.sv ====
`default_nettype none

package gpu_pkg;

    // Bus and network widths
    typedef logic [31:0] addr_t;
    typedef logic [63:0] data_t;
    typedef logic [7:0]  strb_t;
    typedef logic [3:0]  axi_id_t;
    typedef logic [1:0]  resp_t;
    typedef logic [5:0]  node_id_t;
    typedef logic [9:0]  payload_t;
    typedef logic [9:0]  word_index_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;
    localparam resp_t RESP_DECERR = 2'b11;

    localparam int MEM_WORDS = 1024;

    // Memory sits below the register block
    localparam addr_t MEM_LIMIT  = 32'h2000;
    localparam addr_t REG_TX     = 32'h2000;
    localparam addr_t REG_RX     = 32'h2008;
    localparam addr_t REG_STATUS = 32'h2010;

    localparam int RXQ_DEPTH = 4;
    localparam int RXQ_PTR_W = 2;

    // Destination travels in the upper six bits
    typedef struct packed {
        node_id_t dest;
        payload_t payload;
    } flit_t;

    typedef struct packed {
        axi_id_t    id;
        addr_t      addr;
        logic [7:0] len;
        logic [2:0] size;
        logic [1:0] burst;
    } axi_aw_t;

    typedef struct packed {
        axi_id_t    id;
        addr_t      addr;
        logic [7:0] len;
        logic [2:0] size;
        logic [1:0] burst;
    } axi_ar_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
        logic  last;
    } axi_w_t;

    typedef struct packed {
        axi_id_t id;
        resp_t   resp;
    } axi_b_t;

    typedef struct packed {
        axi_id_t id;
        data_t   data;
        resp_t   resp;
        logic    last;
    } axi_r_t;

    typedef struct packed {
        logic        we;
        word_index_t index;
        data_t       wdata;
        strb_t       strb;
    } mem_req_t;

    typedef struct packed {
        logic  tx_write;
        logic  rx_pop;
        flit_t tx_flit;
    } reg_req_t;

    typedef struct packed {
        flit_t      rx_head;
        logic       rx_valid;
        logic [2:0] rx_count;
        logic       tx_busy;
        logic [7:0] drop_count;
    } reg_status_t;

    typedef enum logic [2:0] {
        S_INIT,
        S_IDLE,
        S_WDATA,
        S_WRESP,
        S_RACCESS,
        S_RWAIT,
        S_RRESP
    } slave_state_t;

endpackage

`default_nettype wire
